// File: src/proc_macros.svh
/*
 * Processor front-end constants
 * Widths, instruction cache geometry, bus command encodings and fetch credits
 */
`ifndef PROC_MACROS_SVH
`define PROC_MACROS_SVH

// Datapath widths
`define XLEN            32
`define MEM_DATA_W      64
`define MEM_TAG_W       4      // Zero tag means no transaction

// Instruction cache geometry, direct mapped with 8-byte lines
`define ICACHE_LINES    32
`define ICACHE_IDX_W    5
`define ICACHE_OFS_W    3
`define ICACHE_TAG_W    (`XLEN - `ICACHE_IDX_W - `ICACHE_OFS_W)

// Memory bus commands
`define BUS_CMD_W       2
`define BUS_CMD_NONE    2'h0
`define BUS_CMD_LOAD    2'h1
`define BUS_CMD_STORE   2'h2

// Fetch packet flow control
`define FETCH_CREDITS   4
`define CREDIT_W        3

`endif

// File: src/proc_pkg.sv
/*
 * Processor front-end types
 * Vector typedefs, state enums and the packed memory and fetch structs
 */
`include "proc_macros.svh"

package proc_pkg;

    typedef logic [`XLEN-1:0]       addr_t;
    typedef logic [`XLEN-1:0]       inst_t;
    typedef logic [`MEM_DATA_W-1:0] mem_data_t;   // Two instructions per line
    typedef logic [`MEM_TAG_W-1:0]  mem_tag_t;    // Zero means none
    typedef logic [`CREDIT_W-1:0]   credit_t;

    typedef enum logic [`BUS_CMD_W-1:0] {
        BUS_NONE  = `BUS_CMD_NONE,
        BUS_LOAD  = `BUS_CMD_LOAD,
        BUS_STORE = `BUS_CMD_STORE
    } bus_cmd_e;

    // Instruction cache miss handling
    typedef enum logic [1:0] {
        IC_IDLE,   // Looking up, no miss in flight
        IC_REQ,    // Line request on the bus until accepted
        IC_WAIT    // Accepted, waiting for the return tag
    } icache_state_e;

    // Requester to memory
    typedef struct packed {
        bus_cmd_e  cmd;
        addr_t     addr;
        mem_data_t data;
    } mem_req_t;

    // Memory to requester
    typedef struct packed {
        mem_tag_t  response;   // Same-cycle acceptance tag
        mem_tag_t  tag;        // Tag of the returning data
        mem_data_t data;
    } mem_rsp_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_pkt_t;

endpackage

// File: src/fetch_stage.sv
/*
 * Fetch stage
 * Program counter with redirect, credit counter for the packet consumer
 * and the registered fetch packet
 */
`timescale 1ns/1ps
`include "proc_macros.svh"

module fetch_stage (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                redirect_valid,
    input  proc_pkg::addr_t     redirect_pc,
    input  logic                hit,
    input  proc_pkg::inst_t     inst,
    input  logic                credit_return,
    output proc_pkg::addr_t     fetch_pc,
    output logic                fetch_valid,
    output proc_pkg::fetch_pkt_t fetch_pkt
);

    import proc_pkg::*;

    addr_t   pc;
    credit_t credits;
    logic    have_credit;
    logic    fire;

    assign have_credit = (credits != '0);

    // A redirect cycle never fetches, so the cycle after it is empty
    assign fire = hit && have_credit && !redirect_valid;

    assign fetch_pc = pc;

    //////////////////////////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (fire) begin
            pc <= pc + addr_t'(4);   // Sequential fetch
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Credits and packet
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_t'(`FETCH_CREDITS);
        end else begin
            case ({fire, credit_return})
                2'b10:   credits <= credits - credit_t'(1);
                2'b01:   credits <= credits + credit_t'(1);
                default: credits <= credits;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= fire;
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            fetch_pkt.pc   <= pc;
            fetch_pkt.inst <= inst;
        end
    end

endmodule

// File: src/icache.sv
/*
 * Instruction cache
 * Direct mapped, 8-byte lines, one outstanding line fill toward memory
 */
`timescale 1ns/1ps
`include "proc_macros.svh"

module icache (
    input  logic                clock,
    input  logic                rst_n,
    input  proc_pkg::addr_t     fetch_pc,
    output logic                hit,
    output proc_pkg::inst_t     inst,
    output proc_pkg::mem_req_t  ireq,
    input  proc_pkg::mem_rsp_t  irsp
);

    import proc_pkg::*;

    // Line storage
    mem_data_t                  data_mem [`ICACHE_LINES];
    logic [`ICACHE_TAG_W-1:0]   tag_mem  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]   valid;

    logic [`ICACHE_IDX_W-1:0]   rd_idx;
    logic [`ICACHE_TAG_W-1:0]   rd_tag;
    mem_data_t                  rd_line;

    icache_state_e              state;
    icache_state_e              state_nxt;
    addr_t                      miss_addr;   // Line-aligned
    mem_tag_t                   miss_tag;
    logic                       fill;
    logic [`ICACHE_IDX_W-1:0]   fill_idx;

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////

    assign rd_idx  = fetch_pc[`ICACHE_OFS_W +: `ICACHE_IDX_W];   // PC[7:3]
    assign rd_tag  = fetch_pc[`XLEN-1 -: `ICACHE_TAG_W];
    assign rd_line = data_mem[rd_idx];

    assign hit  = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign inst = fetch_pc[2] ? rd_line[`MEM_DATA_W-1 -: `XLEN] : rd_line[`XLEN-1:0];

    //////////////////////////////////////////////////////////////////////
    // Miss state machine
    //////////////////////////////////////////////////////////////////////

    // Return for our tag ends the wait
    assign fill     = (state == IC_WAIT) && (irsp.tag != '0) && (irsp.tag == miss_tag);
    assign fill_idx = miss_addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];

    always_comb begin
        state_nxt = state;
        case (state)
            IC_IDLE: if (!hit)                   state_nxt = IC_REQ;
            IC_REQ:  if (irsp.response != '0)    state_nxt = IC_WAIT;
            IC_WAIT: if (fill)                   state_nxt = IC_IDLE;
            default:                             state_nxt = IC_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IC_IDLE;
            miss_tag <= '0;
        end else begin
            state <= state_nxt;
            if (state == IC_REQ && irsp.response != '0) begin
                miss_tag <= irsp.response;   // Accepted this cycle
            end
        end
    end

    // Miss line address, captured on entry to the request state
    always_ff @(posedge clock) begin
        if (state == IC_IDLE && !hit) begin
            miss_addr <= {fetch_pc[`XLEN-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};
        end
    end

    // Line request, repeated every cycle until a nonzero response tag
    always_comb begin
        ireq.cmd  = (state == IC_REQ) ? BUS_LOAD : BUS_NONE;
        ireq.addr = miss_addr;
        ireq.data = '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Fill
    //////////////////////////////////////////////////////////////////////

    // Line is written even if fetch has been redirected away
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            data_mem[fill_idx] <= irsp.data;
            tag_mem[fill_idx]  <= miss_addr[`XLEN-1 -: `ICACHE_TAG_W];
        end
    end

endmodule

// File: src/cache_arbiter.sv
/*
 * Cache arbiter
 * Shares the memory port, data side first, and steers returns by tag owner
 */
`timescale 1ns/1ps
`include "proc_macros.svh"

module cache_arbiter (
    input  logic                clock,
    input  logic                rst_n,
    input  proc_pkg::mem_req_t  ireq,
    output proc_pkg::mem_rsp_t  irsp,
    input  proc_pkg::mem_req_t  dreq,
    output proc_pkg::mem_rsp_t  drsp,
    output proc_pkg::mem_req_t  mem_req,
    input  proc_pkg::mem_rsp_t  mem_rsp
);

    import proc_pkg::*;

    localparam int NUM_TAGS = 1 << `MEM_TAG_W;

    logic                d_sel;
    logic                i_sel;
    logic [NUM_TAGS-1:0] own_i;        // Tag held by instruction side
    logic [NUM_TAGS-1:0] own_d;        // Tag held by data side
    logic [NUM_TAGS-1:0] own_i_nxt;
    logic [NUM_TAGS-1:0] own_d_nxt;
    logic                ret_i;
    logic                ret_d;

    //////////////////////////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////////////////////////

    assign d_sel = (dreq.cmd != BUS_NONE);
    assign i_sel = !d_sel && (ireq.cmd != BUS_NONE);

    assign mem_req = d_sel ? dreq : ireq;   // Idle icache drives BUS_NONE

    //////////////////////////////////////////////////////////////////////
    // Return side
    //////////////////////////////////////////////////////////////////////

    assign ret_i = (mem_rsp.tag != '0) && own_i[mem_rsp.tag];
    assign ret_d = (mem_rsp.tag != '0) && own_d[mem_rsp.tag];

    always_comb begin
        // Acceptance goes only to the chosen requester
        irsp.response = i_sel ? mem_rsp.response : '0;
        drsp.response = d_sel ? mem_rsp.response : '0;

        irsp.tag  = ret_i ? mem_rsp.tag  : '0;
        irsp.data = ret_i ? mem_rsp.data : '0;
        drsp.tag  = ret_d ? mem_rsp.tag  : '0;
        drsp.data = ret_d ? mem_rsp.data : '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Tag ownership table
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        own_i_nxt = own_i;
        own_d_nxt = own_d;

        // Retire first, a tag can be reissued in its return cycle
        if (mem_rsp.tag != '0) begin
            own_i_nxt[mem_rsp.tag] = 1'b0;
            own_d_nxt[mem_rsp.tag] = 1'b0;
        end

        if (mem_rsp.response != '0) begin
            if (d_sel) begin
                own_d_nxt[mem_rsp.response] = 1'b1;
            end else if (i_sel) begin
                own_i_nxt[mem_rsp.response] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            own_i <= '0;
            own_d <= '0;
        end else begin
            own_i <= own_i_nxt;
            own_d <= own_d_nxt;
        end
    end

endmodule

// File: src/processor_front.sv
/*
 * Processor front end
 * Fetch stage, instruction cache and memory arbiter with a data-side port
 */
`timescale 1ns/1ps

module processor_front (
    input  logic                 clock,
    input  logic                 rst_n,
    output proc_pkg::mem_req_t   mem_req,
    input  proc_pkg::mem_rsp_t   mem_rsp,
    input  proc_pkg::mem_req_t   dreq,
    output proc_pkg::mem_rsp_t   drsp,
    input  logic                 redirect_valid,
    input  proc_pkg::addr_t      redirect_pc,
    input  logic                 credit_return,
    output logic                 fetch_valid,
    output proc_pkg::fetch_pkt_t fetch_pkt
);

    import proc_pkg::*;

    addr_t    fetch_pc;   // Fetch to icache
    logic     hit;
    inst_t    inst;
    mem_req_t ireq;       // Icache to arbiter
    mem_rsp_t irsp;

    //////////////////////////////////////////////////////////////////////
    // Fetch and instruction cache
    //////////////////////////////////////////////////////////////////////

    fetch_stage fetch_stage_0 (
        .clock          (clock),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .hit            (hit),
        .inst           (inst),
        .credit_return  (credit_return),
        .fetch_pc       (fetch_pc),
        .fetch_valid    (fetch_valid),
        .fetch_pkt      (fetch_pkt)
    );

    icache icache_0 (
        .clock    (clock),
        .rst_n    (rst_n),
        .fetch_pc (fetch_pc),
        .hit      (hit),
        .inst     (inst),
        .ireq     (ireq),
        .irsp     (irsp)
    );

    // Single memory port shared with the data side
    cache_arbiter cache_arbiter_0 (
        .clock   (clock),
        .rst_n   (rst_n),
        .ireq    (ireq),
        .irsp    (irsp),
        .dreq    (dreq),
        .drsp    (drsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

// File: dv/processor_front_chk.sv
/*
 * Front-end checker
 * Bound assertions on reset state, fetch packets, credits and data-side returns
 */
`timescale 1ns/1ps
`include "proc_macros.svh"

module processor_front_chk (
    input logic                 clock,
    input logic                 rst_n,
    input proc_pkg::mem_req_t   mem_req,
    input proc_pkg::mem_req_t   dreq,
    input proc_pkg::mem_rsp_t   drsp,
    input logic                 redirect_valid,
    input proc_pkg::addr_t      redirect_pc,
    input logic                 credit_return,
    input logic                 fetch_valid,
    input proc_pkg::fetch_pkt_t fetch_pkt
);

    import proc_pkg::*;

    localparam logic [31:0] MEM_KEY = 32'h5a5a_0000;

    int unsigned                  fail_count = 0;   // Polled by the testbench
    addr_t                        exp_pc;           // Next in-order packet PC
    int                           outstanding;
    addr_t                        d_addr [1 << `MEM_TAG_W];
    logic [(1 << `MEM_TAG_W)-1:0] d_live;           // Tags held by data loads

    // Memory content of the 8-byte line around an address
    function automatic mem_data_t line_of(input addr_t a);
        addr_t base;
        base = {a[`XLEN-1:3], 3'b000};
        return {(base + 32'd4) ^ MEM_KEY, base ^ MEM_KEY};
    endfunction

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc      <= '0;
            outstanding <= 0;
            d_live      <= '0;
        end else begin
            if (redirect_valid) begin
                exp_pc <= redirect_pc;
            end else if (fetch_valid) begin
                exp_pc <= fetch_pkt.pc + 32'd4;
            end
            outstanding <= outstanding + int'(fetch_valid) - int'(credit_return);
            if (drsp.tag != '0) begin
                d_live[drsp.tag] <= 1'b0;
            end
            if (drsp.response != '0) begin
                d_live[drsp.response] <= 1'b1;   // Set wins on a reused tag
            end
        end
    end

    always_ff @(posedge clock) begin
        if (drsp.response != '0) begin
            d_addr[drsp.response] <= dreq.addr;
        end
    end

    reset_idle: assert property (@(posedge clock)
        $rose(rst_n) |-> !fetch_valid && mem_req.cmd == BUS_NONE)
        else begin
            $error("Fetch or memory bus active in the first cycle after reset");
            fail_count++;
        end

    inst_value: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_valid |-> fetch_pkt.inst == (fetch_pkt.pc ^ MEM_KEY))
        else begin
            $error("MISMATCH time %0t fetch_pkt.inst expected %h actual %h", $time,
                   $sampled(fetch_pkt.pc) ^ MEM_KEY, $sampled(fetch_pkt.inst));
            fail_count++;
        end

    pc_order: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_valid |-> fetch_pkt.pc == exp_pc)
        else begin
            $error("MISMATCH time %0t fetch_pkt.pc expected %h actual %h", $time,
                   $sampled(exp_pc), $sampled(fetch_pkt.pc));
            fail_count++;
        end

    credit_bound: assert property (@(posedge clock) disable iff (!rst_n)
        outstanding <= `FETCH_CREDITS)
        else begin
            $error("More fetch packets outstanding than credits granted");
            fail_count++;
        end

    drsp_owner: assert property (@(posedge clock) disable iff (!rst_n)
        drsp.tag != '0 |-> d_live[drsp.tag])
        else begin
            $error("Return on the data port for a tag no data load holds");
            fail_count++;
        end

    drsp_data: assert property (@(posedge clock) disable iff (!rst_n)
        drsp.tag != '0 && d_live[drsp.tag] |-> drsp.data == line_of(d_addr[drsp.tag]))
        else begin
            $error("MISMATCH time %0t drsp.data expected %h actual %h", $time,
                   line_of(d_addr[$sampled(drsp.tag)]), $sampled(drsp.data));
            fail_count++;
        end

endmodule

// File: dv/tb_processor_front.sv
/*
 * Testbench for the processor front end
 * Tagged memory model, data-side loads, credit return and four fetch tests
 */
`timescale 1ns/1ps
`include "proc_macros.svh"

module tb_processor_front;

    import proc_pkg::*;

    localparam logic [31:0] MEM_KEY    = 32'h5a5a_0000;
    localparam int          MAX_CYCLES = 2 * 2000;   // Twice the four tests together

    logic        clock = 1'b0;
    logic        rst_n;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    mem_req_t    dreq;
    mem_rsp_t    drsp;
    logic        redirect_valid;
    addr_t       redirect_pc;
    logic        credit_return = 1'b0;
    logic        fetch_valid;
    fetch_pkt_t  fetch_pkt;

    integer      seed = 32'hd4df;
    int          cycles = 0;
    int          pkt_count = 0;
    int          held = 0;          // Packets not yet given back as credits
    int          d_out = 0;         // Data loads waiting for their return
    int          tests = 0;
    int          bad_tests = 0;
    int unsigned fails_seen = 0;
    logic        hold_credits = 1'b0;

    // Memory model, one slot per tag
    logic [15:0] live = '0;
    addr_t       m_addr [16];
    int          m_cnt [16];
    logic        accept_ok = 1'b0;
    mem_tag_t    free_tag = '0;
    mem_tag_t    ret_tag = '0;
    mem_data_t   ret_data = '0;

    processor_front i_dut (.*);

    bind processor_front processor_front_chk i_chk (
        .clock          (clock),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .dreq           (dreq),
        .drsp           (drsp),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .credit_return  (credit_return),
        .fetch_valid    (fetch_valid),
        .fetch_pkt      (fetch_pkt)
    );

    always #4 clock = ~clock;

    function automatic mem_data_t mem_line(input addr_t a);
        addr_t base;
        base = {a[31:3], 3'b000};
        return {(base + 32'd4) ^ MEM_KEY, base ^ MEM_KEY};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Memory model, credit consumer and watchdog
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_rsp.response = (mem_req.cmd != BUS_NONE && accept_ok) ? free_tag : '0;
        mem_rsp.tag      = ret_tag;
        mem_rsp.data     = ret_data;
    end

    always begin
        @(posedge clock);
        #1;
        ret_tag  = '0;
        ret_data = '0;
        free_tag = '0;
        for (int t = 1; t < 16; t++) begin
            if (live[t]) begin
                m_cnt[t]--;
                if (m_cnt[t] <= 0 && ret_tag == '0) begin   // One return per cycle
                    ret_tag  = mem_tag_t'(t);
                    ret_data = mem_line(m_addr[t]);
                    live[t]  = 1'b0;
                end
            end
        end
        for (int t = 15; t >= 1; t--) begin
            if (!live[t]) free_tag = mem_tag_t'(t);
        end
        accept_ok = ($random(seed) & 3) != 0;   // Refuse about one in four
        @(negedge clock);
        if (mem_rsp.response != '0) begin
            live[mem_rsp.response]   = 1'b1;
            m_addr[mem_rsp.response] = mem_req.addr;
            m_cnt[mem_rsp.response]  = 2 + int'($unsigned($random(seed)) % 8);
        end
    end

    always @(negedge clock) begin
        pkt_count += int'(fetch_valid);
        held      += int'(fetch_valid) - int'(credit_return);
        d_out     += int'(drsp.response != '0) - int'(drsp.tag != '0);
    end

    always @(posedge clock) begin
        #1;
        credit_return = !hold_credits && held > 0;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_packets(input int n);
        int target;
        target = pkt_count + n;
        while (pkt_count < target) next_cycle();
    endtask

    task automatic redirect_to(input addr_t pc);
        next_cycle();
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        next_cycle();
        redirect_valid = 1'b0;
    endtask

    // Holds the load on the port until a nonzero response tag
    task automatic data_load(input addr_t a);
        next_cycle();
        dreq.cmd  = BUS_LOAD;
        dreq.addr = a;
        @(negedge clock);
        while (drsp.response == '0) begin
            next_cycle();
            @(negedge clock);
        end
        next_cycle();
        dreq.cmd = BUS_NONE;
    endtask

    task automatic end_test(input string name);
        int unsigned fails;
        fails      = i_dut.i_chk.fail_count - fails_seen;
        fails_seen = i_dut.i_chk.fail_count;
        tests++;
        if (fails != 0) bad_tests++;
        $display("Test %0d %s: %s, %0d assertion failures", tests, name,
                 (fails == 0) ? "ok" : "FAILED", fails);
    endtask

    initial begin
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        dreq           = '0;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        wait_packets(40);
        end_test("straight-line fetch");

        hold_credits = 1'b1;   // Consumer stops freeing packets
        while (held < `FETCH_CREDITS) next_cycle();
        repeat (20) next_cycle();
        hold_credits = 1'b0;
        wait_packets(8);
        end_test("credit starvation");

        redirect_to(32'h0000_0400);
        wait_packets(6);
        redirect_to(32'h0000_1ffc);   // Upper half, then next line
        wait_packets(4);
        redirect_to(32'h0000_3000);
        redirect_to(32'h0000_0010);   // Leaves the 3000 fill behind
        wait_packets(6);
        end_test("redirects");

        redirect_to(32'h0000_8000);
        for (int i = 0; i < 8; i++) begin
            data_load(addr_t'($random(seed) & 32'h0000_fff8));
        end
        while (d_out != 0) next_cycle();
        wait_packets(4);
        end_test("data loads with fetch misses");

        $display("%0d tests, %0d failing, %0d assertion failures", tests, bad_tests,
                 fails_seen);
        if (bad_tests == 0 && fails_seen == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: processor_front.f
+incdir+src
src/proc_pkg.sv
src/fetch_stage.sv
src/icache.sv
src/cache_arbiter.sv
src/processor_front.sv
dv/processor_front_chk.sv
dv/tb_processor_front.sv

// File: run.sh
#!/bin/sh
# Build the front end with its testbench, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_processor_front \
    -f processor_front.f -o tb_processor_front > build.log 2>&1 &&
./obj_dir/tb_processor_front +verilator+error+limit+1000 > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
